// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // lanes per word, each one byte wide
    localparam int N_LANES = 4;

    // one lane of a memory word
    typedef logic [7:0] lane_t;

    // full data word as seen on a port
    typedef logic [31:0] word_t;

    // one write-enable bit per lane
    typedef logic [N_LANES-1:0] lane_mask_t;

    // byte position inside a word, the low address bits
    typedef logic [1:0] offset_t;

    // store-control code from the core
    typedef logic [2:0] store_ctrl_t;

    // store widths
    // any other code leaves memory untouched (read or idle)
    localparam store_ctrl_t STORE_BYTE = 3'd1;
    localparam store_ctrl_t STORE_HALF = 3'd2;
    localparam store_ctrl_t STORE_WORD = 3'd4;

endpackage

// ==== logic/lane_steer.sv ====
`timescale 1ns/100ps

module lane_steer #(
    parameter int WADDR_W = 11
) (
    input  logic [WADDR_W+1:0]   addr,
    input  mem_pkg::word_t       din,
    output logic [WADDR_W-1:0]   lane_addr [mem_pkg::N_LANES],
    output mem_pkg::lane_t       lane_din [mem_pkg::N_LANES]
);

    localparam int ADDR_W = WADDR_W + 2;
    localparam int LANE_W = $bits(mem_pkg::lane_t);

    mem_pkg::offset_t       offset;
    logic [WADDR_W-1:0]     word_addr;
    logic [WADDR_W-1:0]     word_addr_inc;
    mem_pkg::lane_t         din_bytes [mem_pkg::N_LANES];

    // split the byte address into word and offset
    assign offset    = addr[1:0];
    assign word_addr = addr[ADDR_W-1:2];

    // next word, shared by all lanes below the offset
    assign word_addr_inc = word_addr + 1'b1;

    for (genvar k = 0; k < mem_pkg::N_LANES; k++) begin : g_lane
        localparam mem_pkg::offset_t LANE = mem_pkg::offset_t'(k);

        mem_pkg::offset_t byte_sel;

        assign din_bytes[k] = din[LANE_W*k +: LANE_W];

        // lanes below the offset belong to the following word
        assign lane_addr[k] = (LANE < offset) ? word_addr_inc : word_addr;

        // write byte i lands on lane (offset + i) mod 4,
        // so lane k takes byte (k - offset) mod 4
        assign byte_sel    = LANE - offset;
        assign lane_din[k] = din_bytes[byte_sel];
    end

endmodule

// ==== logic/store_mask.sv ====
`timescale 1ns/100ps

module store_mask (
    input  mem_pkg::store_ctrl_t store_ctrl,
    input  mem_pkg::offset_t     offset,
    output mem_pkg::lane_mask_t  wmask
);

    mem_pkg::lane_mask_t                 run;
    logic [2*mem_pkg::N_LANES-1:0]       run_shift;

    // lane run starting at lane 0, by store width
    always_comb begin
        case (store_ctrl)
            mem_pkg::STORE_BYTE: run = 4'b0001;
            mem_pkg::STORE_HALF: run = 4'b0011;
            mem_pkg::STORE_WORD: run = 4'b1111;
            default:             run = 4'b0000;
        endcase
    end

    // rotate the run up to the offset
    // the doubled copy makes the upper half wrap lane 3 into lane 0
    assign run_shift = {run, run} << offset;
    assign wmask     = run_shift[2*mem_pkg::N_LANES-1:mem_pkg::N_LANES];

endmodule

// ==== logic/lane_bank.sv ====
`timescale 1ns/100ps

module lane_bank #(
    parameter int WADDR_W = 11
) (
    input  logic                  clk_1,
    input  logic                  rst_n_sync,
    input  logic                  en,
    input  mem_pkg::offset_t      offset,
    input  mem_pkg::lane_mask_t   wmask,
    input  logic [WADDR_W-1:0]    lane_addr [mem_pkg::N_LANES],
    input  mem_pkg::lane_t        lane_din [mem_pkg::N_LANES],
    output mem_pkg::word_t        dout
);

    localparam int DEPTH  = 1 << WADDR_W;
    localparam int LANE_W = $bits(mem_pkg::lane_t);

    mem_pkg::lane_t     rd_bytes [mem_pkg::N_LANES];
    mem_pkg::offset_t   rd_offset;

    for (genvar k = 0; k < mem_pkg::N_LANES; k++) begin : g_lane
        mem_pkg::lane_t mem [DEPTH];
        mem_pkg::lane_t rd_q;

        // byte array, write only where the mask allows
        always_ff @(posedge clk_1) begin
            if (en && wmask[k]) begin
                mem[lane_addr[k]] <= lane_din[k];
            end
        end

        // old contents are captured, a write in the same cycle shows up next read
        always_ff @(posedge clk_1 or negedge rst_n_sync) begin
            if (!rst_n_sync) begin
                rd_q <= '0;
            end else if (en) begin
                rd_q <= mem[lane_addr[k]];
            end
        end

        assign rd_bytes[k] = rd_q;
    end

    // offset of the enabled access, needed to undo the lane rotation
    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            rd_offset <= '0;
        end else if (en) begin
            rd_offset <= offset;
        end
    end

    // byte i of the word sits in lane (offset + i) mod 4
    for (genvar i = 0; i < mem_pkg::N_LANES; i++) begin : g_align
        localparam mem_pkg::offset_t POS = mem_pkg::offset_t'(i);

        mem_pkg::offset_t lane_sel;

        assign lane_sel                  = rd_offset + POS;
        assign dout[LANE_W*i +: LANE_W]  = rd_bytes[lane_sel];
    end

endmodule

// ==== logic/mem_interface.sv ====
`timescale 1ns/100ps

module mem_interface #(
    parameter int WADDR_W = 11
) (
    input  logic                   clk_1,
    input  logic                   rst_n_sync,
    input  logic                   imem_en,
    input  logic                   mem_en,
    input  mem_pkg::store_ctrl_t   storecntrl_a,
    input  mem_pkg::store_ctrl_t   storecntrl_b,
    input  logic [WADDR_W+1:0]     imem_addr,
    input  logic [WADDR_W+1:0]     mem_addr,
    input  mem_pkg::word_t         imem_din,
    input  mem_pkg::word_t         mem_din,
    output mem_pkg::word_t         imem_dout,
    output mem_pkg::word_t         mem_dout
);

    // instruction port lanes
    logic [WADDR_W-1:0]     i_lane_addr [mem_pkg::N_LANES];
    mem_pkg::lane_t         i_lane_din [mem_pkg::N_LANES];
    mem_pkg::lane_mask_t    i_wmask;

    // data port lanes
    logic [WADDR_W-1:0]     d_lane_addr [mem_pkg::N_LANES];
    mem_pkg::lane_t         d_lane_din [mem_pkg::N_LANES];
    mem_pkg::lane_mask_t    d_wmask;

    // instruction memory
    lane_steer #(
        .WADDR_W    (WADDR_W)
    ) u_isteer (
        .addr       (imem_addr),
        .din        (imem_din),
        .lane_addr  (i_lane_addr),
        .lane_din   (i_lane_din)
    );

    store_mask u_imask (
        .store_ctrl (storecntrl_a),
        .offset     (imem_addr[1:0]),
        .wmask      (i_wmask)
    );

    lane_bank #(
        .WADDR_W    (WADDR_W)
    ) u_ibank (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .en         (imem_en),
        .offset     (imem_addr[1:0]),
        .wmask      (i_wmask),
        .lane_addr  (i_lane_addr),
        .lane_din   (i_lane_din),
        .dout       (imem_dout)
    );

    // data memory, same structure, fully separate storage
    lane_steer #(
        .WADDR_W    (WADDR_W)
    ) u_dsteer (
        .addr       (mem_addr),
        .din        (mem_din),
        .lane_addr  (d_lane_addr),
        .lane_din   (d_lane_din)
    );

    store_mask u_dmask (
        .store_ctrl (storecntrl_b),
        .offset     (mem_addr[1:0]),
        .wmask      (d_wmask)
    );

    lane_bank #(
        .WADDR_W    (WADDR_W)
    ) u_dbank (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .en         (mem_en),
        .offset     (mem_addr[1:0]),
        .wmask      (d_wmask),
        .lane_addr  (d_lane_addr),
        .lane_din   (d_lane_din),
        .dout       (mem_dout)
    );

endmodule

// ==== sim/mem_checker.sv ====
`timescale 1ns/100ps

module mem_checker (
    input  logic            clk_1,
    input  logic            rst_n_sync,
    input  mem_pkg::word_t  imem_dout,
    input  mem_pkg::word_t  mem_dout,
    input  logic            chk_due,
    input  logic            chk_port,
    input  mem_pkg::word_t  chk_exp,
    output int              error_count,
    output int              check_count
);

    int     errors = 0;
    int     checks = 0;
    logic   reset_checked = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_word(
        input string            name,
        input mem_pkg::word_t   expected,
        input mem_pkg::word_t   actual
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s at %0t: expected %08h, actual %08h",
                     name, $time, expected, actual);
        end
    endtask

    // douts change only after a rising edge, so the edge sees the settled value
    always @(posedge clk_1) begin
        if (rst_n_sync) begin
            // first edge out of reset
            if (!reset_checked) begin
                if (imem_dout !== '0 || mem_dout !== '0) begin
                    errors++;
                    $display("dout not zero after reset release: imem_dout %08h, mem_dout %08h",
                             imem_dout, mem_dout);
                end
                reset_checked = 1'b1;
            end
            if (chk_due) begin
                if (chk_port) begin
                    compare_word("mem_dout", chk_exp, mem_dout);
                end else begin
                    compare_word("imem_dout", chk_exp, imem_dout);
                end
            end
        end
    end

endmodule

// ==== sim/tb_mem_interface.sv ====
`timescale 1ns/100ps

module tb_mem_interface;

    localparam int    WADDR_W      = 11;
    localparam int    ADDR_W       = WADDR_W + 2;
    localparam int    CLK_HALF     = 4;
    localparam int    RESET_CYCLES = 8;
    localparam string INPUT_FILE   = "sim/mem_input.txt";

    logic                   clk_1;
    logic                   rst_n_sync;
    logic                   imem_en;
    logic                   mem_en;
    mem_pkg::store_ctrl_t   storecntrl_a;
    mem_pkg::store_ctrl_t   storecntrl_b;
    logic [ADDR_W-1:0]      imem_addr;
    logic [ADDR_W-1:0]      mem_addr;
    mem_pkg::word_t         imem_din;
    mem_pkg::word_t         mem_din;
    mem_pkg::word_t         imem_dout;
    mem_pkg::word_t         mem_dout;

    // one entry per access line of the input file
    logic                   line_port [$];
    logic                   line_en [$];
    mem_pkg::store_ctrl_t   line_ctrl [$];
    logic [ADDR_W-1:0]      line_addr [$];
    mem_pkg::word_t         line_din [$];
    mem_pkg::word_t         line_exp [$];
    int                     n_lines;
    logic                   table_ready;

    // expected result of the access one cycle back
    logic                   chk_due;
    logic                   chk_port;
    mem_pkg::word_t         chk_exp;

    int                     check_errors;
    int                     n_checks;
    int                     tb_errors;

    always #CLK_HALF clk_1 = ~clk_1;

    mem_interface #(
        .WADDR_W        (WADDR_W)
    ) UUT (
        .clk_1          (clk_1),
        .rst_n_sync     (rst_n_sync),
        .imem_en        (imem_en),
        .mem_en         (mem_en),
        .storecntrl_a   (storecntrl_a),
        .storecntrl_b   (storecntrl_b),
        .imem_addr      (imem_addr),
        .mem_addr       (mem_addr),
        .imem_din       (imem_din),
        .mem_din        (mem_din),
        .imem_dout      (imem_dout),
        .mem_dout       (mem_dout)
    );

    mem_checker u_check (
        .clk_1          (clk_1),
        .rst_n_sync     (rst_n_sync),
        .imem_dout      (imem_dout),
        .mem_dout       (mem_dout),
        .chk_due        (chk_due),
        .chk_port       (chk_port),
        .chk_exp        (chk_exp),
        .error_count    (check_errors),
        .check_count    (n_checks)
    );

    // a store returns the old word, which the table does not track
    function automatic logic read_expected(input logic en, input mem_pkg::store_ctrl_t ctrl);
        if (!en) begin
            return 1'b1;
        end
        return !(ctrl == mem_pkg::STORE_BYTE || ctrl == mem_pkg::STORE_HALF ||
                 ctrl == mem_pkg::STORE_WORD);
    endfunction

    task automatic load_table();
        int             fd;
        int             n_fields;
        string          text;
        logic [31:0]    port_v;
        logic [31:0]    en_v;
        logic [31:0]    ctrl_v;
        logic [31:0]    addr_v;
        logic [31:0]    din_v;
        logic [31:0]    exp_v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", INPUT_FILE);
            tb_errors++;
        end else begin
            while ($fgets(text, fd) != 0) begin
                // comment lines do not parse as six fields
                n_fields = $sscanf(text, "%h %h %h %h %h %h",
                                   port_v, en_v, ctrl_v, addr_v, din_v, exp_v);
                if (n_fields == 6) begin
                    line_port.push_back(port_v[0]);
                    line_en.push_back(en_v[0]);
                    line_ctrl.push_back(ctrl_v[2:0]);
                    line_addr.push_back(addr_v[ADDR_W-1:0]);
                    line_din.push_back(din_v);
                    line_exp.push_back(exp_v);
                end
            end
            $fclose(fd);
        end
        n_lines = line_port.size();
        if (n_lines == 0) begin
            $display("stimulus file holds no access lines");
            tb_errors++;
        end
    endtask

    // the other port keeps its enable low
    task automatic drive_line(input int idx);
        if (line_port[idx]) begin
            imem_en      = 1'b0;
            mem_en       = line_en[idx];
            storecntrl_b = line_ctrl[idx];
            mem_addr     = line_addr[idx];
            mem_din      = line_din[idx];
        end else begin
            mem_en       = 1'b0;
            imem_en      = line_en[idx];
            storecntrl_a = line_ctrl[idx];
            imem_addr    = line_addr[idx];
            imem_din     = line_din[idx];
        end
    endtask

    task automatic print_summary();
        $display("errors: %0d from checks, %0d from testbench, %0d checks run",
                 check_errors, tb_errors, n_checks);
    endtask

    initial begin
        logic           pend_due;
        logic           pend_port;
        mem_pkg::word_t pend_exp;
        clk_1        = 1'b0;
        rst_n_sync   = 1'b0;
        imem_en      = 1'b0;
        mem_en       = 1'b0;
        storecntrl_a = '0;
        storecntrl_b = '0;
        imem_addr    = '0;
        mem_addr     = '0;
        imem_din     = '0;
        mem_din      = '0;
        chk_due      = 1'b0;
        chk_port     = 1'b0;
        chk_exp      = '0;
        tb_errors    = 0;
        table_ready  = 1'b0;
        pend_due     = 1'b0;
        pend_port    = 1'b0;
        pend_exp     = '0;
        load_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_1);
        rst_n_sync = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            @(negedge clk_1);
            chk_due   = pend_due;
            chk_port  = pend_port;
            chk_exp   = pend_exp;
            drive_line(i);
            pend_due  = read_expected(line_en[i], line_ctrl[i]);
            pend_port = line_port[i];
            pend_exp  = line_exp[i];
        end
        // last access still has its result in flight
        @(negedge clk_1);
        imem_en  = 1'b0;
        mem_en   = 1'b0;
        chk_due  = pend_due;
        chk_port = pend_port;
        chk_exp  = pend_exp;
        @(negedge clk_1);
        chk_due = 1'b0;
        if (n_checks == 0) begin
            $display("no read checks were run");
            tb_errors++;
        end
        print_summary();
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // generous bound, four cycles per access line
    initial begin
        wait (table_ready === 1'b1);
        #((n_lines * 4 + 100) * 2 * CLK_HALF);
        $display("timeout: stimulus did not finish");
        tb_errors++;
        print_summary();
        $display("Something failed");
        $finish;
    end

endmodule

// ==== sim/mem_input.txt ====
# port (0 instruction, 1 data), en, store code (1 byte, 2 half, 4 word, else read)
# byte address, write data, expected dout one cycle later (stores are not checked)
# idle lines (en 0) expect the port's dout to hold its last value
0 0 0 0000 00000000 00000000
1 0 0 0000 00000000 00000000
0 1 4 0010 11223344 00000000
0 1 0 0010 00000000 11223344
1 1 4 0010 cafef00d 00000000
1 1 0 0010 00000000 cafef00d
0 1 0 0010 00000000 11223344
0 0 0 0010 00000000 11223344
1 0 0 0010 00000000 cafef00d
1 1 4 0020 87654321 00000000
1 1 1 0021 deadbeaa 00000000
1 1 2 0022 5555bbcc 00000000
1 1 0 0020 00000000 bbccaa21
1 1 4 0024 ffffffff 00000000
1 1 1 0027 00000012 00000000
1 1 2 0024 99993456 00000000
1 1 0 0024 00000000 12ff3456
1 1 2 0025 0000789a 00000000
1 1 0 0024 00000000 12789a56
0 1 1 0010 000000ee 00000000
0 1 1 0012 00000077 00000000
0 1 0 0010 00000000 117733ee
1 1 4 0040 00000000 00000000
1 1 4 0044 00000000 00000000
1 1 4 0041 a1b2c3d4 00000000
1 1 0 0041 00000000 a1b2c3d4
1 1 0 0040 00000000 b2c3d400
1 1 0 0044 00000000 000000a1
1 1 4 0052 0f1e2d3c 00000000
1 1 0 0052 00000000 0f1e2d3c
1 1 4 0043 01020304 00000000
1 1 0 0043 00000000 01020304
1 1 0 0040 00000000 04c3d400
1 1 0 0044 00000000 00010203
1 1 4 0048 00000000 00000000
1 1 2 0047 0000beef 00000000
1 1 0 0044 00000000 ef010203
1 1 0 0048 00000000 000000be
0 0 0 0000 00000000 117733ee
1 0 0 0000 00000000 000000be

// ==== verilog.f ====
logic/mem_pkg.sv
logic/lane_steer.sv
logic/store_mask.sv
logic/lane_bank.sv
logic/mem_interface.sv
sim/mem_checker.sv
sim/tb_mem_interface.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' verilog.f)

.PHONY: run clean

run: obj_dir/Vtb_mem_interface sim/mem_input.txt
	obj_dir/Vtb_mem_interface > sim.log
	cat sim.log
	! grep -q "Something failed" sim.log

obj_dir/Vtb_mem_interface: verilog.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_mem_interface -f verilog.f

clean:
	rm -rf obj_dir sim.log
